// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lc4_processor
FILELIST  ?= all.f
LOG       ?= sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_alu.sv
lc4_processor.sv
lc4_asserts.sv
tb_lc4_processor.sv

// ==== lc4_alu.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_alu import lc4_pkg::*; (
    input  alu_op_t i_op,
    input  insn_t   i_insn,
    input  word_t   i_rs,
    input  word_t   i_rt,
    output word_t   o_result
);

    word_t imm5;
    word_t imm6;
    word_t imm9;

    // Sign-extended immediates
    assign imm5 = {{(`LC4_WORD_W-5){i_insn[4]}}, i_insn[4:0]};
    assign imm6 = {{(`LC4_WORD_W-6){i_insn[5]}}, i_insn[5:0]};
    assign imm9 = {{(`LC4_WORD_W-9){i_insn[8]}}, i_insn[8:0]};

    always_comb begin
        case (i_op)
            ALU_ADD:   o_result = i_rs + i_rt;
            ALU_SUB:   o_result = i_rs - i_rt;
            ALU_AND:   o_result = i_rs & i_rt;
            ALU_ADDI:  o_result = i_rs + imm5;
            // CONST ignores both operands
            ALU_CONST: o_result = imm9;
            // Base plus offset for LDR and STR
            ALU_ADDR:  o_result = i_rs + imm6;
            default:   o_result = '0;
        endcase
    end

endmodule

// ==== lc4_asserts.sv ====
`timescale 1ns/1ps

module lc4_asserts import lc4_pkg::*; (
    input logic    gwe,
    input logic    i_reset,
    input word_t   i_cur_pc,
    input logic    i_load_use_stall,
    input retire_t i_retire
);

    // Store flag only on a real slot
    store_real_slot: assert property (@(posedge gwe) disable iff (i_reset)
        i_retire.dmem_we |-> i_retire.stall == STALL_NONE)
        else $error("store flag on an empty or bubble slot");

    // Inserted bubble writes nothing
    bubble_no_write: assert property (@(posedge gwe) disable iff (i_reset)
        i_retire.stall == STALL_LOAD_USE |->
            !(i_retire.regfile_we || i_retire.nzp_we || i_retire.dmem_we))
        else $error("load-use bubble carries a write enable");

    // Fetch freezes for the stalled cycle
    pc_hold: assert property (@(posedge gwe) disable iff (i_reset)
        i_load_use_stall |=> i_cur_pc == $past(i_cur_pc))
        else $error("PC advanced during a load-use stall");

endmodule

// ==== lc4_decoder.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decoder import lc4_pkg::*; (
    input  insn_t    i_insn,
    output ctrl_t    o_ctrl,
    output reg_sel_t o_r1sel,
    output reg_sel_t o_r2sel,
    output reg_sel_t o_wsel
);

    logic [3:0] opcode;
    logic [2:0] subop;

    assign opcode = i_insn[15:12];
    assign subop  = i_insn[5:3];

    // Base register always sits in [8:6]
    assign o_r1sel = i_insn[8:6];
    // STR reads its data register from [11:9], others use rt in [2:0]
    assign o_r2sel = (opcode == `LC4_OP_STR) ? i_insn[11:9] : i_insn[2:0];
    // Destination field; for a store it names the data register
    assign o_wsel  = i_insn[11:9];

    always_comb begin
        // Unknown opcodes fall through as NOP
        o_ctrl = '0;
        case (opcode)
            `LC4_OP_ARITH: begin
                if (i_insn[5]) begin
                    // ADD with 5-bit immediate
                    o_ctrl.r1re       = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    o_ctrl.alu_op     = ALU_ADDI;
                end else if (subop == `LC4_SUB_ADD || subop == `LC4_SUB_SUB) begin
                    o_ctrl.r1re       = 1'b1;
                    o_ctrl.r2re       = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    o_ctrl.alu_op     = (subop == `LC4_SUB_SUB) ? ALU_SUB : ALU_ADD;
                end
            end
            `LC4_OP_AND: begin
                // Register AND shares the 000 sub-op with ADD
                if (subop == `LC4_SUB_ADD) begin
                    o_ctrl.r1re       = 1'b1;
                    o_ctrl.r2re       = 1'b1;
                    o_ctrl.regfile_we = 1'b1;
                    o_ctrl.nzp_we     = 1'b1;
                    o_ctrl.alu_op     = ALU_AND;
                end
            end
            `LC4_OP_LDR: begin
                o_ctrl.r1re       = 1'b1;
                o_ctrl.regfile_we = 1'b1;
                o_ctrl.nzp_we     = 1'b1;
                o_ctrl.is_load    = 1'b1;
                o_ctrl.alu_op     = ALU_ADDR;
            end
            `LC4_OP_STR: begin
                o_ctrl.r1re     = 1'b1;
                o_ctrl.r2re     = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.alu_op   = ALU_ADDR;
            end
            `LC4_OP_CONST: begin
                o_ctrl.regfile_we = 1'b1;
                o_ctrl.nzp_we     = 1'b1;
                o_ctrl.alu_op     = ALU_CONST;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

// ==== lc4_hazard_unit.sv ====
`timescale 1ns/1ps

module lc4_hazard_unit import lc4_pkg::*; (
    input  ctrl_t      i_dec_ctrl,
    input  reg_sel_t   i_dec_r1sel,
    input  reg_sel_t   i_dec_r2sel,
    input  de_t        i_ex,
    input  em_t        i_mem,
    input  mw_t        i_wb,
    output logic       o_load_use_stall,
    output logic [1:0] o_fwd_rs,
    output logic [1:0] o_fwd_rt
);

    // Bit 0 picks the memory stage, bit 1 the writeback stage
    function automatic logic [1:0] fwd_sel(reg_sel_t sel, logic re, em_t mem, mw_t wb);
        logic mem_hit;
        logic wb_hit;
        // A load in memory has no value yet, the result there is the address
        mem_hit = re && mem.ctrl.regfile_we && !mem.ctrl.is_load && mem.wsel == sel;
        wb_hit  = re && wb.ctrl.regfile_we && wb.wsel == sel;
        // Younger producer wins
        return {wb_hit && !mem_hit, mem_hit};
    endfunction

    logic r1_dep;
    logic r2_dep;

    // Decode reads what the load in execute will write
    assign r1_dep = i_dec_ctrl.r1re && i_dec_r1sel == i_ex.wsel;
    // Store data is patched later in memory, so only non-stores stall on r2
    assign r2_dep = i_dec_ctrl.r2re && !i_dec_ctrl.is_store && i_dec_r2sel == i_ex.wsel;

    assign o_load_use_stall = i_ex.ctrl.is_load && (r1_dep || r2_dep);

    assign o_fwd_rs = fwd_sel(i_ex.r1sel, i_ex.ctrl.r1re, i_mem, i_wb);
    assign o_fwd_rt = fwd_sel(i_ex.r2sel, i_ex.ctrl.r2re, i_mem, i_wb);

endmodule

// ==== lc4_macros.svh ====
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// Datapath and register file sizes
`define LC4_WORD_W    16
`define LC4_REG_SEL_W 3
`define LC4_NUM_REGS  8

// Boot address of user code
`define LC4_RESET_PC 16'h8200

// All-zero word, a never-taken branch in LC4, used as the pipeline NOP
`define LC4_NOP_INSN 16'h0000

// Opcodes in insn[15:12]
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_AND   4'b0101
`define LC4_OP_LDR   4'b0110
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

// Arithmetic sub-ops in insn[5:3]
`define LC4_SUB_ADD 3'b000
`define LC4_SUB_SUB 3'b010

`endif

// ==== lc4_pkg.sv ====
`include "lc4_macros.svh"

package lc4_pkg;

    // One machine word of data or address
    typedef logic [`LC4_WORD_W-1:0] word_t;
    // One instruction word
    typedef logic [`LC4_WORD_W-1:0] insn_t;
    // Register number
    typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;
    // Condition codes, N Z P from left to right
    typedef logic [2:0] nzp_t;

    // Operation carried out by the execute stage
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ADDI,
        ALU_CONST,
        ALU_ADDR
    } alu_op_t;

    // Slot code seen on the retirement trace
    typedef enum logic [1:0] {
        STALL_NONE     = 2'b00,
        STALL_EMPTY    = 2'b10,
        STALL_LOAD_USE = 2'b11
    } stall_t;

    // Decoded control bits, all zero for a NOP
    typedef struct packed {
        logic    r1re;
        logic    r2re;
        logic    regfile_we;
        logic    nzp_we;
        logic    is_load;
        logic    is_store;
        alu_op_t alu_op;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        word_t    pc;
        insn_t    insn;
        ctrl_t    ctrl;
        reg_sel_t r1sel;
        reg_sel_t r2sel;
        reg_sel_t wsel;
        word_t    rs_data;
        word_t    rt_data;
        stall_t   stall;
    } de_t;

    // Execute to memory
    typedef struct packed {
        word_t    pc;
        insn_t    insn;
        ctrl_t    ctrl;
        reg_sel_t wsel;
        word_t    alu_result;
        word_t    store_data;
        stall_t   stall;
    } em_t;

    // Memory to writeback
    typedef struct packed {
        word_t    pc;
        insn_t    insn;
        ctrl_t    ctrl;
        reg_sel_t wsel;
        word_t    alu_result;
        word_t    load_data;
        stall_t   stall;
    } mw_t;

    // One retired slot per cycle
    typedef struct packed {
        stall_t   stall;
        word_t    pc;
        insn_t    insn;
        logic     regfile_we;
        reg_sel_t wsel;
        word_t    wdata;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dmem_we;
    } retire_t;

endpackage

// ==== lc4_processor.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_processor import lc4_pkg::*; (
    input  logic    gwe,
    input  logic    i_reset,
    output word_t   o_cur_pc,
    input  insn_t   i_cur_insn,
    output word_t   o_dmem_addr,
    input  word_t   i_dmem_data,
    output logic    o_dmem_we,
    output word_t   o_dmem_wdata,
    output retire_t o_retire
);

    word_t      pc_q;
    word_t      fd_pc;
    insn_t      fd_insn;
    de_t        de_d;
    de_t        de_q;
    em_t        em_d;
    em_t        em_q;
    mw_t        mw_d;
    mw_t        mw_q;

    ctrl_t      dec_ctrl;
    reg_sel_t   dec_r1sel;
    reg_sel_t   dec_r2sel;
    reg_sel_t   dec_wsel;
    word_t      rs_data;
    word_t      rt_data;

    logic       load_use_stall;
    logic [1:0] fwd_rs;
    logic [1:0] fwd_rt;
    word_t      ex_rs;
    word_t      ex_rt;
    word_t      alu_result;

    logic       wm_bypass;
    word_t      wb_wdata;
    nzp_t       wb_nzp;

    // Fetch, PC holds during a load-use stall
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q <= `LC4_RESET_PC;
        end else if (!load_use_stall) begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    assign o_cur_pc = pc_q;

    // Fetch to decode register, frozen with the PC
    always_ff @(posedge gwe) begin
        if (!load_use_stall) begin
            fd_pc <= pc_q;
        end
        if (i_reset) begin
            fd_insn <= `LC4_NOP_INSN;
        end else if (!load_use_stall) begin
            fd_insn <= i_cur_insn;
        end
    end

    // Decode
    lc4_decoder lc4_decoder_i (
        .i_insn  (fd_insn),
        .o_ctrl  (dec_ctrl),
        .o_r1sel (dec_r1sel),
        .o_r2sel (dec_r2sel),
        .o_wsel  (dec_wsel)
    );

    lc4_regfile lc4_regfile_i (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs      (dec_r1sel),
        .i_rt      (dec_r2sel),
        .i_rd      (mw_q.wsel),
        .i_rd_we   (mw_q.ctrl.regfile_we),
        .i_wdata   (wb_wdata),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    lc4_hazard_unit lc4_hazard_unit_i (
        .i_dec_ctrl       (dec_ctrl),
        .i_dec_r1sel      (dec_r1sel),
        .i_dec_r2sel      (dec_r2sel),
        .i_ex             (de_q),
        .i_mem            (em_q),
        .i_wb             (mw_q),
        .o_load_use_stall (load_use_stall),
        .o_fwd_rs         (fwd_rs),
        .o_fwd_rt         (fwd_rt)
    );

    always_comb begin
        de_d.pc      = fd_pc;
        de_d.r1sel   = dec_r1sel;
        de_d.r2sel   = dec_r2sel;
        de_d.wsel    = dec_wsel;
        de_d.rs_data = rs_data;
        de_d.rt_data = rt_data;
        // On a stall a bubble goes to execute while decode keeps its insn
        if (load_use_stall) begin
            de_d.insn  = `LC4_NOP_INSN;
            de_d.ctrl  = '0;
            de_d.stall = STALL_LOAD_USE;
        end else begin
            de_d.insn  = fd_insn;
            de_d.ctrl  = dec_ctrl;
            de_d.stall = (fd_insn == `LC4_NOP_INSN) ? STALL_EMPTY : STALL_NONE;
        end
    end

    // Execute with MX and WX forwarding
    assign ex_rs = fwd_rs[0] ? em_q.alu_result : (fwd_rs[1] ? wb_wdata : de_q.rs_data);
    assign ex_rt = fwd_rt[0] ? em_q.alu_result : (fwd_rt[1] ? wb_wdata : de_q.rt_data);

    lc4_alu lc4_alu_i (
        .i_op     (de_q.ctrl.alu_op),
        .i_insn   (de_q.insn),
        .i_rs     (ex_rs),
        .i_rt     (ex_rt),
        .o_result (alu_result)
    );

    assign em_d = '{pc: de_q.pc, insn: de_q.insn, ctrl: de_q.ctrl, wsel: de_q.wsel,
                    alu_result: alu_result, store_data: ex_rt, stall: de_q.stall};

    // Memory, store data picks up a load result sitting in writeback
    assign wm_bypass = em_q.ctrl.is_store && mw_q.ctrl.regfile_we && mw_q.wsel == em_q.wsel;

    assign o_dmem_addr  = (em_q.ctrl.is_load || em_q.ctrl.is_store) ? em_q.alu_result : '0;
    assign o_dmem_we    = em_q.ctrl.is_store;
    assign o_dmem_wdata = wm_bypass ? wb_wdata : em_q.store_data;

    assign mw_d = '{pc: em_q.pc, insn: em_q.insn, ctrl: em_q.ctrl, wsel: em_q.wsel,
                    alu_result: em_q.alu_result, load_data: i_dmem_data, stall: em_q.stall};

    // Stage registers, only insn, controls and slot code are reset
    always_ff @(posedge gwe) begin
        de_q <= de_d;
        em_q <= em_d;
        mw_q <= mw_d;
        if (i_reset) begin
            de_q.insn  <= `LC4_NOP_INSN;
            de_q.ctrl  <= '0;
            de_q.stall <= STALL_EMPTY;
            em_q.insn  <= `LC4_NOP_INSN;
            em_q.ctrl  <= '0;
            em_q.stall <= STALL_EMPTY;
            mw_q.insn  <= `LC4_NOP_INSN;
            mw_q.ctrl  <= '0;
            mw_q.stall <= STALL_EMPTY;
        end
    end

    // Writeback value and its condition codes
    assign wb_wdata = mw_q.ctrl.is_load ? mw_q.load_data : mw_q.alu_result;
    assign wb_nzp   = wb_wdata[`LC4_WORD_W-1] ? 3'b100 :
                      (wb_wdata == '0)        ? 3'b010 : 3'b001;

    // Trace of the slot leaving writeback
    assign o_retire = '{stall: mw_q.stall, pc: mw_q.pc, insn: mw_q.insn,
                        regfile_we: mw_q.ctrl.regfile_we, wsel: mw_q.wsel,
                        wdata: wb_wdata, nzp_we: mw_q.ctrl.nzp_we, nzp: wb_nzp,
                        dmem_we: mw_q.ctrl.is_store};

endmodule

// ==== lc4_regfile.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_reset,
    input  reg_sel_t i_rs,
    input  reg_sel_t i_rt,
    input  reg_sel_t i_rd,
    input  logic     i_rd_we,
    input  word_t    i_wdata,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);

    word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Writeback to decode bypass, decode sees the value being written this cycle
    assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// ==== lc4_stim.txt ====
// @000 counts: program words, data pairs, retire records, load-use bubbles
// @010 program at 0x8200, @040 data as address value,
// @060 records: pc insn regfile_we wsel wdata nzp_we nzp(4=N 2=Z 1=P) dmem_we
@000
0013 0004 0013 0004
@010
9205 95FD 1642 18D1 5B02 1D23 1DBF 9E20
63C0 1441 67C1 18E0 75C2 6BC2 7BC3 6DC3
1195 63C1 5541
@040
0020 1234
0021 8001
0022 5555
0023 AAAA
@060
8200 9205 1 1 0005 1 1 0
8201 95FD 1 2 FFFD 1 4 0
8202 1642 1 3 0002 1 1 0
8203 18D1 1 4 FFFD 1 4 0
8204 5B02 1 5 FFFD 1 4 0
8205 1D23 1 6 0000 1 2 0
8206 1DBF 1 6 FFFF 1 4 0
8207 9E20 1 7 0020 1 1 0
8208 63C0 1 1 1234 1 1 0
8209 1441 1 2 2468 1 1 0
820A 67C1 1 3 8001 1 4 0
820B 18E0 1 4 8001 1 4 0
820C 75C2 0 0 0000 0 0 1
820D 6BC2 1 5 2468 1 1 0
820E 7BC3 0 0 0000 0 0 1
820F 6DC3 1 6 2468 1 1 0
8210 1195 1 0 0000 1 2 0
8211 63C1 1 1 8001 1 4 0
8212 5541 1 2 0000 1 2 0

// ==== tb_lc4_processor.sv ====
`timescale 1ns/1ps
`include "lc4_macros.svh"

module tb_lc4_processor import lc4_pkg::*; ();

    // Word offsets inside the stimulus image
    localparam int PROG_BASE      = 'h10;
    localparam int DATA_BASE      = 'h40;
    localparam int REC_BASE       = 'h60;
    localparam int REC_WORDS      = 8;
    localparam int RETIRE_TIMEOUT = 200;
    localparam int DRAIN_CYCLES   = 10;

    logic    gwe;
    logic    i_reset;
    word_t   cur_pc;
    insn_t   cur_insn;
    word_t   dmem_addr;
    word_t   dmem_rdata;
    logic    dmem_we;
    word_t   dmem_wdata;
    retire_t retire;

    logic [15:0] imem [0:65535];
    logic [15:0] dmem [0:65535];
    logic [15:0] stim [0:511];

    lc4_processor lc4_processor_i (
        .gwe          (gwe),
        .i_reset      (i_reset),
        .o_cur_pc     (cur_pc),
        .i_cur_insn   (cur_insn),
        .o_dmem_addr  (dmem_addr),
        .i_dmem_data  (dmem_rdata),
        .o_dmem_we    (dmem_we),
        .o_dmem_wdata (dmem_wdata),
        .o_retire     (retire)
    );

    bind lc4_processor lc4_asserts lc4_asserts_i (
        .gwe              (gwe),
        .i_reset          (i_reset),
        .i_cur_pc         (o_cur_pc),
        .i_load_use_stall (load_use_stall),
        .i_retire         (o_retire)
    );

    initial gwe = 1'b0;
    always #4 gwe = ~gwe;

    // Both memories answer in the same cycle
    assign cur_insn   = imem[cur_pc];
    assign dmem_rdata = dmem[dmem_addr];

    // Store lands on the rising edge
    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // LCG step with the Numerical Recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // One field of an expected retirement record
    function automatic logic [31:0] rec_field(input int idx, input int field);
        int addr;
        addr = REC_BASE + idx * REC_WORDS + field;
        return 32'(stim[addr[8:0]]);
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Cleared pipeline where nothing may write
    task automatic check_reset_outputs(input string tag);
        check_value({tag, " pc"}, 32'(`LC4_RESET_PC), 32'(cur_pc));
        check_value({tag, " dmem_we"}, 32'd0, 32'(dmem_we));
        check_value({tag, " stall"}, 32'(STALL_EMPTY), 32'(retire.stall));
        check_value({tag, " regfile_we"}, 32'd0, 32'(retire.regfile_we));
        check_value({tag, " nzp_we"}, 32'd0, 32'(retire.nzp_we));
        check_value({tag, " trace dmem_we"}, 32'd0, 32'(retire.dmem_we));
    endtask

    // Register and NZP fields only matter when their enable is set
    task automatic check_retire(input int idx);
        string tag;
        tag = $sformatf("retire[%0d]", idx);
        check_value({tag, " pc"}, rec_field(idx, 0), 32'(retire.pc));
        check_value({tag, " insn"}, rec_field(idx, 1), 32'(retire.insn));
        check_value({tag, " regfile_we"}, rec_field(idx, 2), 32'(retire.regfile_we));
        if (rec_field(idx, 2) != 0) begin
            check_value({tag, " wsel"}, rec_field(idx, 3), 32'(retire.wsel));
            check_value({tag, " wdata"}, rec_field(idx, 4), 32'(retire.wdata));
        end
        check_value({tag, " nzp_we"}, rec_field(idx, 5), 32'(retire.nzp_we));
        if (rec_field(idx, 5) != 0) begin
            check_value({tag, " nzp"}, rec_field(idx, 6), 32'(retire.nzp));
        end
        check_value({tag, " dmem_we"}, rec_field(idx, 7), 32'(retire.dmem_we));
    endtask

    initial begin
        logic [31:0] seed;
        word_t       addr;
        int          n_prog;
        int          n_data;
        int          n_rec;
        int          n_bubbles;
        int          rec_idx;
        int          bubbles;
        int          cycles;

        i_reset = 1'b1;
        $readmemh("lc4_stim.txt", stim);
        n_prog    = 32'(stim[0]);
        n_data    = 32'(stim[1]);
        n_rec     = 32'(stim[2]);
        n_bubbles = 32'(stim[3]);

        // Fetch past the program sees NOPs
        // Data words get noise tied to the address
        seed = 32'h2aacefe6;
        for (int a = 0; a < 65536; a++) begin
            seed = lcg_next(seed);
            imem[a[15:0]] = `LC4_NOP_INSN;
            dmem[a[15:0]] = seed[31:16] ^ a[15:0];
        end
        for (int i = 0; i < n_prog; i++) begin
            addr = `LC4_RESET_PC + 16'(i);
            imem[addr] = stim[9'(PROG_BASE + i)];
        end
        for (int i = 0; i < n_data; i++) begin
            dmem[stim[9'(DATA_BASE + 2 * i)]] = stim[9'(DATA_BASE + 2 * i + 1)];
        end

        // Four rising edges under reset
        for (int c = 0; c < 4; c++) begin
            @(negedge gwe);
            check_reset_outputs($sformatf("reset cycle %0d", c));
        end
        i_reset = 1'b0;

        rec_idx = 0;
        bubbles = 0;
        cycles  = 0;
        while (rec_idx < n_rec) begin
            @(negedge gwe);
            cycles++;
            if (cycles > RETIRE_TIMEOUT) begin
                report_failure("Timeout waiting for the expected retirements");
            end
            if (retire.stall == STALL_NONE) begin
                check_retire(rec_idx);
                rec_idx++;
            end else begin
                if (retire.stall == STALL_LOAD_USE) begin
                    bubbles++;
                end
                check_value("empty slot regfile_we", 32'd0, 32'(retire.regfile_we));
                check_value("empty slot nzp_we", 32'd0, 32'(retire.nzp_we));
                check_value("empty slot dmem_we", 32'd0, 32'(retire.dmem_we));
            end
        end

        // Only NOP slots may follow the last instruction
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge gwe);
            if (retire.stall != STALL_EMPTY) begin
                report_failure("A slot other than an empty one retired after the program");
            end
        end
        check_value("load_use_count", n_bubbles, bubbles);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
